// ==== common/mac_arith_pkg.sv ====
package mac_arith_pkg;

  // One matrix element, two's complement
  localparam int DWIDTH = 8;

  typedef logic signed [DWIDTH-1:0] elem_t;

  // Full product, or split for the range check
  typedef union packed {
    logic signed [2*DWIDTH-1:0] full;
    struct packed {
      logic              sign;
      // Bits 14 to 7, must all equal the sign to fit in a byte
      logic [DWIDTH-1:0] ovf;
      logic [DWIDTH-2:0] mag;
    } parts;
  } prod_word_u;

  // Clamp a 16-bit product into -128..127
  function automatic elem_t saturate_product(prod_word_u p);
    elem_t res;
    if (!p.parts.sign) begin
      // Positive, any high bit set means too large
      res = (|p.parts.ovf) ? {1'b0, {(DWIDTH-1){1'b1}}} : {1'b0, p.parts.mag};
    end else begin
      // Negative, fits only if the high bits are all ones
      res = (&p.parts.ovf) ? {1'b1, p.parts.mag} : {1'b1, {(DWIDTH-1){1'b0}}};
    end
    return res;
  endfunction

endpackage

// ==== common/matmul_cfg_pkg.sv ====
package matmul_cfg_pkg;

  //////////////////////////////////////////////////
  // Array dimension and bus widths
  //////////////////////////////////////////////////

  // Default edge length of the square array
  localparam int MAT_SIZE     = 4;
  // Operand and result memory address width
  localparam int AWIDTH       = 11;
  // Address step between consecutive columns or rows
  localparam int STRIDE_WIDTH = 8;
  // Cycle counter width, plenty for small arrays
  localparam int CNT_WIDTH    = 8;

  //////////////////////////////////////////////////
  // Pipeline timing
  //////////////////////////////////////////////////

  // Read data follows the address by this many cycles
  localparam int MEM_LATENCY  = 1;
  // Operand flop, product flop, accumulator flop
  localparam int MAC_STAGES   = 3;

  // Last pair reaches cell (n-1,n-1) at (n-1) + 1 + latency + 2(n-1),
  // and its sum shows up MAC_STAGES cycles later
  function automatic int LATCH_CYCLE(int n);
    return 3 * n - 2 + MEM_LATENCY + MAC_STAGES;
  endfunction

  // Done once the shifter has put out all but its last column
  function automatic int DONE_CYCLE(int n);
    return LATCH_CYCLE(n) + n - 1;
  endfunction

endpackage

// ==== dv/matmul_assertions.sv ====
module matmul_assertions #(
  parameter int MAT_SIZE = matmul_cfg_pkg::MAT_SIZE
) (
  input logic clk,
  input logic reset,
  input logic i_start,
  input logic i_done,
  input logic i_avail
);

  // Cycles of the current available window before this one
  int avail_len;

  always_ff @(posedge clk) begin
    if (reset || !i_avail) begin
      avail_len <= 0;
    end else begin
      avail_len <= avail_len + 1;
    end
  end

  //////////////////////////////////////////////////
  // Top-level timing
  //////////////////////////////////////////////////

  // Done is a single-cycle pulse
  done_pulse: assert property (@(posedge clk) disable iff (reset) i_done |=> !i_done)
    else $error("done held high for more than one cycle");

  // Window never runs past MAT_SIZE columns
  avail_max: assert property (@(posedge clk) disable iff (reset)
    i_avail |-> avail_len < MAT_SIZE)
    else $error("data available held longer than MAT_SIZE cycles");

  // Window never ends early
  avail_min: assert property (@(posedge clk) disable iff (reset)
    (!i_avail && avail_len != 0) |-> avail_len == MAT_SIZE)
    else $error("data available dropped before MAT_SIZE cycles");

  // Results only go out during a requested multiply
  avail_start: assert property (@(posedge clk) disable iff (reset) i_avail |-> i_start)
    else $error("data available high while start is low");

endmodule

bind matmul_top matmul_assertions #(.MAT_SIZE(MAT_SIZE)) u_assertions (
  .clk     (clk),
  .reset   (reset),
  .i_start (i_start_mat_mul),
  .i_done  (o_done_mat_mul),
  .i_avail (o_c_data_available)
);

// ==== dv/matmul_tb.sv ====
module matmul_tb;

  import matmul_cfg_pkg::*;
  import mac_arith_pkg::*;

  localparam int N       = MAT_SIZE;
  localparam int WORD_W  = N * DWIDTH;
  localparam int DEPTH   = 2048;
  localparam int TIMEOUT = 100;

  logic                    clk = 1'b0;
  logic                    reset;
  logic                    i_start_mat_mul;
  logic [AWIDTH-1:0]       i_addr_a;
  logic [AWIDTH-1:0]       i_addr_b;
  logic [AWIDTH-1:0]       i_addr_c;
  logic [STRIDE_WIDTH-1:0] i_stride_a;
  logic [STRIDE_WIDTH-1:0] i_stride_b;
  logic [STRIDE_WIDTH-1:0] i_stride_c;
  logic                    o_done_mat_mul;
  logic [AWIDTH-1:0]       o_a_addr;
  logic [AWIDTH-1:0]       o_b_addr;
  logic [AWIDTH-1:0]       o_c_addr;
  logic [WORD_W-1:0]       o_c_data;
  logic                    o_c_data_available;
  logic [WORD_W-1:0]       a_rd_data = '0;
  logic [WORD_W-1:0]       b_rd_data = '0;

  // Operand memories, A by columns and B by rows
  logic [WORD_W-1:0] mem_a [DEPTH];
  logic [WORD_W-1:0] mem_b [DEPTH];

  // Current operands and the captured result
  int                mat_a [N][N];
  int                mat_b [N][N];
  int                got_c [N][N];
  logic [AWIDTH-1:0] got_addr [N];
  int                n_cols;
  int                done_cnt;
  logic [AWIDTH-1:0] a_trace [$];
  logic [AWIDTH-1:0] b_trace [$];

  logic [31:0] lcg_state = 32'h425bcb2d;
  int          big_vals [4] = '{100, -100, 127, -128};
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  always #4 clk = ~clk;

  matmul_top #(.MAT_SIZE(N)) dut0 (
    .clk                (clk),
    .reset              (reset),
    .i_start_mat_mul    (i_start_mat_mul),
    .i_addr_a           (i_addr_a),
    .i_addr_b           (i_addr_b),
    .i_addr_c           (i_addr_c),
    .i_stride_a         (i_stride_a),
    .i_stride_b         (i_stride_b),
    .i_stride_c         (i_stride_c),
    .i_a_data           (a_rd_data),
    .i_b_data           (b_rd_data),
    .o_done_mat_mul     (o_done_mat_mul),
    .o_a_addr           (o_a_addr),
    .o_b_addr           (o_b_addr),
    .o_c_addr           (o_c_addr),
    .o_c_data           (o_c_data),
    .o_c_data_available (o_c_data_available)
  );

  // Registered read, data one cycle after the address
  always @(posedge clk) begin
    a_rd_data <= mem_a[o_a_addr];
    b_rd_data <= mem_b[o_b_addr];
  end

  //////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////

  function automatic int next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[30:8]);
  endfunction

  function automatic int rand_range(int lo, int hi);
    return lo + next_rand() % (hi - lo + 1);
  endfunction

  // Product limited to one signed byte
  function automatic int clamp_byte(int p);
    if (p > 127) begin
      return 127;
    end
    if (p < -128) begin
      return -128;
    end
    return p;
  endfunction

  // C[r][c] as clamped products summed with 8-bit wrap
  function automatic int expected_elem(int r, int c);
    int                sum;
    logic signed [7:0] wrapped;
    sum = 0;
    for (int k = 0; k < N; k++) begin
      sum += clamp_byte(mat_a[r][k] * mat_b[k][c]);
    end
    wrapped = sum[7:0];
    return int'(wrapped);
  endfunction

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  task automatic random_matrices(input int lo, input int hi);
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        mat_a[r][c] = rand_range(lo, hi);
        mat_b[r][c] = rand_range(lo, hi);
      end
    end
  endtask

  task automatic big_matrices();
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        mat_a[r][c] = big_vals[rand_range(0, 3)];
        mat_b[r][c] = big_vals[rand_range(0, 3)];
      end
    end
  endtask

  task automatic fill_memories(input int base_a, stride_a, base_b, stride_b);
    for (int i = 0; i < DEPTH; i++) begin
      // Background word differs for every address
      mem_a[i] = WORD_W'(i * 32'h9e3779b1);
      mem_b[i] = ~WORD_W'(i * 32'h85ebca6b);
    end
    for (int k = 0; k < N; k++) begin
      for (int e = 0; e < N; e++) begin
        // Word k of A is column k, word k of B is row k
        mem_a[AWIDTH'(base_a + k * stride_a)][e*DWIDTH +: DWIDTH] = DWIDTH'(mat_a[e][k]);
        mem_b[AWIDTH'(base_b + k * stride_b)][e*DWIDTH +: DWIDTH] = DWIDTH'(mat_b[k][e]);
      end
    end
  endtask

  // One full multiply, start left high afterwards if asked
  task automatic run_multiply(input int base_a, stride_a, base_b, stride_b,
                              input int base_c, stride_c, input bit keep_start);
    int cycles;
    fill_memories(base_a, stride_a, base_b, stride_b);
    n_cols = 0;
    done_cnt = 0;
    a_trace.delete();
    b_trace.delete();
    @(posedge clk);
    #1;
    i_addr_a = AWIDTH'(base_a);
    i_addr_b = AWIDTH'(base_b);
    i_addr_c = AWIDTH'(base_c);
    i_stride_a = STRIDE_WIDTH'(stride_a);
    i_stride_b = STRIDE_WIDTH'(stride_b);
    i_stride_c = STRIDE_WIDTH'(stride_c);
    i_start_mat_mul = 1'b1;
    cycles = 0;
    // Sample mid-cycle until done has passed and the drain is over
    do begin
      @(negedge clk);
      cycles++;
      a_trace.push_back(o_a_addr);
      b_trace.push_back(o_b_addr);
      if (o_c_data_available) begin
        if (n_cols < N) begin
          got_addr[n_cols] = o_c_addr;
          for (int r = 0; r < N; r++) begin
            got_c[r][n_cols] = int'(elem_t'(o_c_data[r*DWIDTH +: DWIDTH]));
          end
        end
        n_cols++;
      end
      if (o_done_mat_mul) begin
        done_cnt++;
      end
    end while ((done_cnt == 0 || o_c_data_available) && cycles < TIMEOUT);
    if (done_cnt == 0 || o_c_data_available) begin
      $display("Timeout at %0t: multiply did not finish within %0d cycles", $time, TIMEOUT);
      errors++;
    end
    assert (done_cnt == 1) else begin
      $display("Mismatch at %0t: done pulsed %0d times, expected 1", $time, done_cnt);
      errors++;
    end
    assert (n_cols == N) else begin
      $display("Mismatch at %0t: %0d columns of C, expected %0d", $time, n_cols, N);
      errors++;
    end
    if (!keep_start) begin
      @(posedge clk);
      #1;
      i_start_mat_mul = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Checkers
  //////////////////////////////////////////////////

  task automatic check_results(input int base_c, input int stride_c);
    logic [AWIDTH-1:0] exp_addr;
    int                exp_val;
    for (int j = 0; j < N && j < n_cols; j++) begin
      exp_addr = AWIDTH'(base_c + j * stride_c);
      assert (got_addr[j] == exp_addr) else begin
        $display("Mismatch at %0t: column %0d address %0d expected %0d",
                 $time, j, got_addr[j], exp_addr);
        errors++;
      end
      for (int r = 0; r < N; r++) begin
        exp_val = expected_elem(r, j);
        assert (got_c[r][j] == exp_val) else begin
          $display("Mismatch at %0t: C[%0d][%0d] is %0d expected %0d",
                   $time, r, j, got_c[r][j], exp_val);
          errors++;
        end
      end
    end
  endtask

  // Base must appear, then base + k*stride on consecutive cycles
  task automatic check_addr_walk(input logic [AWIDTH-1:0] trace [$], input int base,
                                 input int stride, input string name);
    int first;
    first = -1;
    foreach (trace[i]) begin
      if (first < 0 && trace[i] == AWIDTH'(base)) begin
        first = i;
      end
    end
    if (first < 0 || first + N > trace.size()) begin
      $display("Address walk on %s never started at base %0d", name, base);
      errors++;
    end else begin
      for (int k = 1; k < N; k++) begin
        assert (trace[first+k] == AWIDTH'(base + k * stride)) else begin
          $display("Mismatch at %0t: %s step %0d is %0d expected %0d", $time, name, k,
                   trace[first+k], AWIDTH'(base + k * stride));
          errors++;
        end
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_idle_after_reset();
    int errs_before;
    errs_before = errors;
    repeat (10) begin
      @(negedge clk);
      assert (!o_done_mat_mul && !o_c_data_available) else begin
        $display("Mismatch at %0t: output active before any start", $time);
        errors++;
      end
    end
    report_test("idle_after_reset", errs_before);
  endtask

  task automatic test_identity();
    int errs_before;
    errs_before = errors;
    random_matrices(-128, 127);
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        mat_a[r][c] = (r == c) ? 1 : 0;
      end
    end
    run_multiply(0, 1, 16, 1, 32, 1, 1'b0);
    check_results(32, 1);
    // Identity times B must give B back
    for (int j = 0; j < N && j < n_cols; j++) begin
      for (int r = 0; r < N; r++) begin
        assert (got_c[r][j] == mat_b[r][j]) else begin
          $display("Mismatch at %0t: C[%0d][%0d] is %0d, B holds %0d",
                   $time, r, j, got_c[r][j], mat_b[r][j]);
          errors++;
        end
      end
    end
    report_test("identity", errs_before);
  endtask

  task automatic test_random_small();
    int errs_before;
    errs_before = errors;
    repeat (3) begin
      random_matrices(-4, 4);
      run_multiply(40, 1, 80, 1, 120, 1, 1'b0);
      check_results(120, 1);
    end
    report_test("random_small", errs_before);
  endtask

  task automatic test_saturation();
    int errs_before;
    errs_before = errors;
    // Column 0 clamps to 127 and wraps to -4, the others clamp to -128 and wrap to 0
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        mat_a[r][c] = 100;
        mat_b[r][c] = (c == 0) ? 100 : -100;
      end
    end
    run_multiply(200, 2, 300, 2, 400, 2, 1'b0);
    check_results(400, 2);
    repeat (2) begin
      big_matrices();
      run_multiply(200, 2, 300, 2, 400, 2, 1'b0);
      check_results(400, 2);
    end
    report_test("saturation", errs_before);
  endtask

  task automatic test_strides();
    int errs_before;
    errs_before = errors;
    random_matrices(-20, 20);
    // C addresses run past the top of the 11-bit space
    run_multiply(100, 7, 1500, 33, 2000, 20, 1'b0);
    check_results(2000, 20);
    check_addr_walk(a_trace, 100, 7, "o_a_addr");
    check_addr_walk(b_trace, 1500, 33, "o_b_addr");
    report_test("strides", errs_before);
  endtask

  task automatic test_restart();
    int errs_before;
    errs_before = errors;
    random_matrices(-4, 4);
    run_multiply(0, 1, 64, 1, 128, 1, 1'b1);
    check_results(128, 1);
    // Start still high, long enough for a second multiply to reach done
    repeat (DONE_CYCLE(N) + 8) begin
      @(negedge clk);
      assert (!o_done_mat_mul && !o_c_data_available) else begin
        $display("Mismatch at %0t: output active while start held after done", $time);
        errors++;
      end
    end
    @(posedge clk);
    #1;
    i_start_mat_mul = 1'b0;
    // New operands, any leftover sum would show here
    random_matrices(-4, 4);
    run_multiply(0, 1, 64, 1, 128, 1, 1'b0);
    check_results(128, 1);
    report_test("restart", errs_before);
  endtask

  initial begin
    reset = 1'b1;
    i_start_mat_mul = 1'b0;
    i_addr_a = '0;
    i_addr_b = '0;
    i_addr_c = '0;
    i_stride_a = '0;
    i_stride_b = '0;
    i_stride_c = '0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    test_idle_after_reset();
    test_identity();
    test_random_small();
    test_saturation();
    test_strides();
    test_restart();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== pe_array/mac_pe.sv ====
module mac_pe (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_clear,
  input  mac_arith_pkg::elem_t i_a,
  input  mac_arith_pkg::elem_t i_b,
  output mac_arith_pkg::elem_t o_a,
  output mac_arith_pkg::elem_t o_b,
  output mac_arith_pkg::elem_t o_acc
);

  import mac_arith_pkg::*;

  // MAC stage 1, local copy of the operands
  elem_t      a_q;
  elem_t      b_q;
  // MAC stage 2, registered full product
  prod_word_u prod_q;

  //////////////////////////////////////////////////
  // Systolic forwarding to right and lower neighbours
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_a <= '0;
      o_b <= '0;
    end else begin
      o_a <= i_a;
      o_b <= i_b;
    end
  end

  //////////////////////////////////////////////////
  // Three-stage MAC
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      a_q    <= '0;
      b_q    <= '0;
      prod_q <= '0;
      o_acc  <= '0;
    end else begin
      a_q         <= i_a;
      b_q         <= i_b;
      // Signed 8x8 into 16 bits, no overflow possible here
      prod_q.full <= a_q * b_q;
      // Product clamped, running sum wraps at 8 bits
      o_acc       <= o_acc + saturate_product(prod_q);
    end
  end

endmodule

// ==== pe_array/pe_array.sv ====
module pe_array #(
  parameter int MAT_SIZE = matmul_cfg_pkg::MAT_SIZE
) (
  input  logic                                               clk,
  input  logic                                               reset,
  input  logic                                               i_acc_clear,
  input  logic [MAT_SIZE*mac_arith_pkg::DWIDTH-1:0]          i_a_lanes,
  input  logic [MAT_SIZE*mac_arith_pkg::DWIDTH-1:0]          i_b_lanes,
  output logic [MAT_SIZE*MAT_SIZE*mac_arith_pkg::DWIDTH-1:0] o_acc_grid
);

  import mac_arith_pkg::*;

  // a_link[r][c] feeds cell (r,c) from the left, column MAT_SIZE falls off the edge
  elem_t a_link [MAT_SIZE][MAT_SIZE+1];
  // b_link[r][c] feeds cell (r,c) from above
  elem_t b_link [MAT_SIZE+1][MAT_SIZE];

  //////////////////////////////////////////////////
  // Array edges
  //////////////////////////////////////////////////

  for (genvar k = 0; k < MAT_SIZE; k++) begin : g_edge
    // Row k of A enters on the left
    assign a_link[k][0] = i_a_lanes[k*DWIDTH +: DWIDTH];
    // Column k of B enters on top
    assign b_link[0][k] = i_b_lanes[k*DWIDTH +: DWIDTH];
  end

  //////////////////////////////////////////////////
  // Cell grid, A moves right and B moves down
  //////////////////////////////////////////////////

  for (genvar r = 0; r < MAT_SIZE; r++) begin : g_row
    for (genvar c = 0; c < MAT_SIZE; c++) begin : g_col
      mac_pe u_pe (
        .clk     (clk),
        .reset   (reset),
        .i_clear (i_acc_clear),
        .i_a     (a_link[r][c]),
        .i_b     (b_link[r][c]),
        .o_a     (a_link[r][c+1]),
        .o_b     (b_link[r+1][c]),
        // Row-major, C[r][c] at element r*MAT_SIZE+c
        .o_acc   (o_acc_grid[(r*MAT_SIZE+c)*DWIDTH +: DWIDTH])
      );
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the systolic multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module matmul_tb
./obj_dir/Vmatmul_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== src/cycle_counter.sv ====
module cycle_counter #(
  parameter int MAT_SIZE = matmul_cfg_pkg::MAT_SIZE
) (
  input  logic clk,
  input  logic reset,
  input  logic i_run,
  output logic o_fetch_en,
  output logic o_latch_tick,
  output logic o_done_tick
);

  import matmul_cfg_pkg::*;

  // Cycle marks for this array size
  localparam int LATCH_CNT = LATCH_CYCLE(MAT_SIZE);
  localparam int DONE_CNT  = DONE_CYCLE(MAT_SIZE);

  // Zero in the first run cycle
  logic [CNT_WIDTH-1:0] clk_cnt;

  always_ff @(posedge clk) begin
    if (reset || !i_run) begin
      clk_cnt <= '0;
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Decodes, qualified by run since the count rests at zero
  //////////////////////////////////////////////////

  // One read per cycle for counts 0..MAT_SIZE-1
  assign o_fetch_en   = i_run && (clk_cnt < CNT_WIDTH'(MAT_SIZE));

  // All accumulators final in this cycle
  assign o_latch_tick = i_run && (clk_cnt == CNT_WIDTH'(LATCH_CNT));

  // Ends the run state
  assign o_done_tick  = i_run && (clk_cnt == CNT_WIDTH'(DONE_CNT));

endmodule

// ==== src/matmul_sequencer.sv ====
module matmul_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic i_start,
  input  logic i_done_tick,
  output logic o_run,
  output logic o_acc_clear,
  output logic o_done
);

  // State encoding
  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_RUN  = 2'd1;
  localparam logic [1:0] S_HOLD = 2'd2;

  logic [1:0] state;

  //////////////////////////////////////////////////
  // State register and done pulse
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= S_IDLE;
      o_done <= 1'b0;
    end else begin
      // Done only on the run to hold transition
      o_done <= (state == S_RUN) && i_start && i_done_tick;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            state <= S_RUN;
          end
        end
        S_RUN: begin
          // Start dropped early, abandon this multiply
          if (!i_start) begin
            state <= S_IDLE;
          end else if (i_done_tick) begin
            state <= S_HOLD;
          end
        end
        S_HOLD: begin
          // Wait for start to go low before rearming
          if (!i_start) begin
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Counter, feeders and shifter advance only in run
  assign o_run       = (state == S_RUN);
  // Accumulators held at zero between multiplies
  assign o_acc_clear = (state == S_IDLE);

endmodule

// ==== src/matmul_top.sv ====
module matmul_top #(
  parameter int MAT_SIZE = matmul_cfg_pkg::MAT_SIZE
) (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                                        i_start_mat_mul,
  input  logic [matmul_cfg_pkg::AWIDTH-1:0]           i_addr_a,
  input  logic [matmul_cfg_pkg::AWIDTH-1:0]           i_addr_b,
  input  logic [matmul_cfg_pkg::AWIDTH-1:0]           i_addr_c,
  input  logic [matmul_cfg_pkg::STRIDE_WIDTH-1:0]     i_stride_a,
  input  logic [matmul_cfg_pkg::STRIDE_WIDTH-1:0]     i_stride_b,
  input  logic [matmul_cfg_pkg::STRIDE_WIDTH-1:0]     i_stride_c,
  input  logic [MAT_SIZE*mac_arith_pkg::DWIDTH-1:0]   i_a_data,
  input  logic [MAT_SIZE*mac_arith_pkg::DWIDTH-1:0]   i_b_data,
  output logic                                        o_done_mat_mul,
  output logic [matmul_cfg_pkg::AWIDTH-1:0]           o_a_addr,
  output logic [matmul_cfg_pkg::AWIDTH-1:0]           o_b_addr,
  output logic [matmul_cfg_pkg::AWIDTH-1:0]           o_c_addr,
  output logic [MAT_SIZE*mac_arith_pkg::DWIDTH-1:0]   o_c_data,
  output logic                                        o_c_data_available
);

  import mac_arith_pkg::*;

  // Sequencer and counter control
  logic run;
  logic acc_clear;
  logic fetch_en;
  logic latch_tick;
  logic done_tick;

  // Skewed operand edges and the result grid
  logic [MAT_SIZE*DWIDTH-1:0]          a_lanes;
  logic [MAT_SIZE*DWIDTH-1:0]          b_lanes;
  logic [MAT_SIZE*MAT_SIZE*DWIDTH-1:0] acc_grid;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  matmul_sequencer u_sequencer (
    .clk         (clk),
    .reset       (reset),
    .i_start     (i_start_mat_mul),
    .i_done_tick (done_tick),
    .o_run       (run),
    .o_acc_clear (acc_clear),
    .o_done      (o_done_mat_mul)
  );

  cycle_counter #(.MAT_SIZE(MAT_SIZE)) u_counter (
    .clk          (clk),
    .reset        (reset),
    .i_run        (run),
    .o_fetch_en   (fetch_en),
    .o_latch_tick (latch_tick),
    .o_done_tick  (done_tick)
  );

  //////////////////////////////////////////////////
  // Operand fetch, A by columns and B by rows
  //////////////////////////////////////////////////

  operand_feeder #(.MAT_SIZE(MAT_SIZE)) feed_a (
    .clk        (clk),
    .reset      (reset),
    .i_run      (run),
    .i_fetch_en (fetch_en),
    .i_base     (i_addr_a),
    .i_stride   (i_stride_a),
    .i_rd_data  (i_a_data),
    .o_addr     (o_a_addr),
    .o_lanes    (a_lanes)
  );

  operand_feeder #(.MAT_SIZE(MAT_SIZE)) feed_b (
    .clk        (clk),
    .reset      (reset),
    .i_run      (run),
    .i_fetch_en (fetch_en),
    .i_base     (i_addr_b),
    .i_stride   (i_stride_b),
    .i_rd_data  (i_b_data),
    .o_addr     (o_b_addr),
    .o_lanes    (b_lanes)
  );

  //////////////////////////////////////////////////
  // Datapath and result drain
  //////////////////////////////////////////////////

  pe_array #(.MAT_SIZE(MAT_SIZE)) u_pe_array (
    .clk         (clk),
    .reset       (reset),
    .i_acc_clear (acc_clear),
    .i_a_lanes   (a_lanes),
    .i_b_lanes   (b_lanes),
    .o_acc_grid  (acc_grid)
  );

  result_shifter #(.MAT_SIZE(MAT_SIZE)) u_result_shifter (
    .clk           (clk),
    .reset         (reset),
    .i_run         (run),
    .i_latch_tick  (latch_tick),
    .i_acc_grid    (acc_grid),
    .i_base_c      (i_addr_c),
    .i_stride_c    (i_stride_c),
    .o_c_data      (o_c_data),
    .o_c_addr      (o_c_addr),
    .o_c_available (o_c_data_available)
  );

endmodule

// ==== src/operand_feeder.sv ====
module operand_feeder #(
  parameter int MAT_SIZE = matmul_cfg_pkg::MAT_SIZE
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      i_run,
  input  logic                                      i_fetch_en,
  input  logic [matmul_cfg_pkg::AWIDTH-1:0]         i_base,
  input  logic [matmul_cfg_pkg::STRIDE_WIDTH-1:0]   i_stride,
  input  logic [MAT_SIZE*mac_arith_pkg::DWIDTH-1:0] i_rd_data,
  output logic [matmul_cfg_pkg::AWIDTH-1:0]         o_addr,
  output logic [MAT_SIZE*mac_arith_pkg::DWIDTH-1:0] o_lanes
);

  import matmul_cfg_pkg::*;
  import mac_arith_pkg::*;

  // Stage 0 marks a live address, the last stage marks live read data
  logic [MEM_LATENCY:0] fetch_pipe;
  logic                 rd_valid;
  // Gated read word split per lane
  elem_t                lane_in [MAT_SIZE];

  //////////////////////////////////////////////////
  // Address generation
  //////////////////////////////////////////////////

  // Parked at base - stride so the first step lands on base
  always_ff @(posedge clk) begin
    if (i_fetch_en) begin
      o_addr <= o_addr + AWIDTH'(i_stride);
    end else begin
      o_addr <= i_base - AWIDTH'(i_stride);
    end
  end

  //////////////////////////////////////////////////
  // Read valid tracking
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_pipe <= '0;
    end else begin
      fetch_pipe <= {fetch_pipe[MEM_LATENCY-1:0], i_fetch_en};
    end
  end

  assign rd_valid = fetch_pipe[MEM_LATENCY];

  // Unread bus cycles feed zeros into the array
  always_comb begin
    for (int r = 0; r < MAT_SIZE; r++) begin
      lane_in[r] = rd_valid ? elem_t'(i_rd_data[r*DWIDTH +: DWIDTH]) : '0;
    end
  end

  //////////////////////////////////////////////////
  // Lane skew, lane r delayed r cycles
  //////////////////////////////////////////////////

  for (genvar r = 0; r < MAT_SIZE; r++) begin : g_lane
    if (r == 0) begin : g_direct
      // Lane 0 enters the edge cell straight from memory
      assign o_lanes[DWIDTH-1:0] = lane_in[0];
    end else begin : g_skew
      elem_t taps [r];

      always_ff @(posedge clk) begin
        if (reset || !i_run) begin
          for (int i = 0; i < r; i++) begin
            taps[i] <= '0;
          end
        end else begin
          taps[0] <= lane_in[r];
          for (int i = 1; i < r; i++) begin
            taps[i] <= taps[i-1];
          end
        end
      end

      assign o_lanes[r*DWIDTH +: DWIDTH] = taps[r-1];
    end
  end

endmodule

// ==== src/result_shifter.sv ====
module result_shifter #(
  parameter int MAT_SIZE = matmul_cfg_pkg::MAT_SIZE
) (
  input  logic                                               clk,
  input  logic                                               reset,
  input  logic                                               i_run,
  input  logic                                               i_latch_tick,
  input  logic [MAT_SIZE*MAT_SIZE*mac_arith_pkg::DWIDTH-1:0] i_acc_grid,
  input  logic [matmul_cfg_pkg::AWIDTH-1:0]                  i_base_c,
  input  logic [matmul_cfg_pkg::STRIDE_WIDTH-1:0]            i_stride_c,
  output logic [MAT_SIZE*mac_arith_pkg::DWIDTH-1:0]          o_c_data,
  output logic [matmul_cfg_pkg::AWIDTH-1:0]                  o_c_addr,
  output logic                                               o_c_available
);

  import matmul_cfg_pkg::*;
  import mac_arith_pkg::*;

  localparam int COL_W = (MAT_SIZE > 1) ? $clog2(MAT_SIZE) : 1;

  // Column chain, entry 0 is the column on the output
  logic [MAT_SIZE*DWIDTH-1:0] col_q [MAT_SIZE];
  // Index of the column now on the output
  logic [COL_W-1:0]           col_idx;

  //////////////////////////////////////////////////
  // Column capture and shift
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_latch_tick) begin
      // Column j gets C[r][j] in lane r
      for (int j = 0; j < MAT_SIZE; j++) begin
        for (int r = 0; r < MAT_SIZE; r++) begin
          col_q[j][r*DWIDTH +: DWIDTH] <= i_acc_grid[(r*MAT_SIZE+j)*DWIDTH +: DWIDTH];
        end
      end
      o_c_addr <= i_base_c;
    end else if (o_c_available) begin
      for (int j = 0; j < MAT_SIZE - 1; j++) begin
        col_q[j] <= col_q[j+1];
      end
      col_q[MAT_SIZE-1] <= '0;
      // Addresses climb with the column index
      o_c_addr <= o_c_addr + AWIDTH'(i_stride_c);
    end
  end

  assign o_c_data = col_q[0];

  //////////////////////////////////////////////////
  // Output valid window, MAT_SIZE cycles long
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || (!i_run && !o_c_available)) begin
      o_c_available <= 1'b0;
      col_idx       <= '0;
    end else if (i_latch_tick) begin
      o_c_available <= 1'b1;
      col_idx       <= '0;
    end else if (o_c_available) begin
      // Last column on the bus this cycle
      if (col_idx == COL_W'(MAT_SIZE - 1)) begin
        o_c_available <= 1'b0;
      end
      col_idx <= col_idx + 1'b1;
    end
  end

endmodule

// ==== verilog.f ====
common/matmul_cfg_pkg.sv
common/mac_arith_pkg.sv
pe_array/mac_pe.sv
pe_array/pe_array.sv
src/matmul_sequencer.sv
src/cycle_counter.sv
src/operand_feeder.sv
src/result_shifter.sv
src/matmul_top.sv
dv/matmul_assertions.sv
dv/matmul_tb.sv
